//--- hw/video_timing_pkg.sv
/* Reduced arcade frame of 64x40 pixels, 48x32 of them visible
   Blanks are active low (1 while visible), sync pulses are active high */
package video_timing_pkg;

    // Frame geometry in pixels and lines
    localparam int H_TOTAL  = 64;
    localparam int H_VIS    = 48;
    localparam int V_TOTAL  = 40;
    localparam int V_VIS    = 32;

    // Sync windows, start and length
    localparam int HS_START = 52;
    localparam int HS_LEN   = 4;   // Pixels
    localparam int VS_START = 35;
    localparam int VS_LEN   = 2;   // Lines

    typedef logic [5:0] hpos_t;
    typedef logic [5:0] vpos_t;

    typedef struct packed {
        logic hs;
        logic vs;
        logic lhbl;   // Low during horizontal blank
        logic lvbl;   // Low during vertical blank
    } video_sync_t;

endpackage

//--- hw/video_gfx_pkg.sv
/* Pixel, colour, object and bus types for the video subsystem
   Pattern regions hold 8 codes of 8x8 pixels, so only code bits 2:0 select a pattern */
package video_gfx_pkg;

    localparam int N_OBJ     = 4;
    localparam int TILE_W    = 8;
    localparam int PAT_CODES = 8;   // 256-byte region, 32 bytes per code

    // Programming regions, prog.addr[9:8]
    localparam logic [1:0] PROG_TILE = 2'd0;
    localparam logic [1:0] PROG_OBJ  = 2'd1;
    localparam logic [1:0] PROG_PAL  = 2'd2;

    typedef logic [3:0] pxl_t;   // 0 is transparent on the object layer

    typedef struct packed {
        logic [3:0] red;
        logic [3:0] green;
        logic [3:0] blue;
    } rgb_t;

    // Byte 3 is y, byte 2 x, byte 1 code and byte 0 attr
    typedef struct packed {
        logic [7:0] y;
        logic [7:0] x;
        logic [7:0] code;
        logic [7:0] attr;   // Bit 7 enables the object
    } obj_fields_t;

    // CPU writes single bytes, the line engine reads fields
    typedef union packed {
        logic [3:0][7:0] bytes;
        obj_fields_t     f;
    } obj_entry_u;

    typedef struct packed {
        logic [7:0] addr;
        logic [7:0] data;
        logic       we;
    } cpu_bus_t;

    typedef struct packed {
        logic [9:0] addr;
        logic [7:0] data;
        logic       en;
    } prog_bus_t;

endpackage

//--- hw/video_timer.sv
/* Free running pixel and line counters, one step per pxl_cen
   Sync and blanks are decoded from the current count with no delay */
`timescale 1ns/1ps

module video_timer (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          pxl_cen,
    output video_timing_pkg::hpos_t       hpos,
    output video_timing_pkg::vpos_t       vpos,
    output video_timing_pkg::video_sync_t sync,
    output logic                          line_start,
    output logic                          hblank_start
);

    logic h_wrap;
    logic v_wrap;

    assign h_wrap = int'(hpos) == video_timing_pkg::H_TOTAL - 1;
    assign v_wrap = int'(vpos) == video_timing_pkg::V_TOTAL - 1;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hpos <= '0;
            vpos <= '0;
        end else if (pxl_cen) begin
            if (h_wrap) begin
                hpos <= '0;
                vpos <= v_wrap ? '0 : vpos + 1'b1;
            end else begin
                hpos <= hpos + 1'b1;
            end
        end
    end

    always_comb begin
        sync.hs   = int'(hpos) >= video_timing_pkg::HS_START &&
                    int'(hpos) <  video_timing_pkg::HS_START + video_timing_pkg::HS_LEN;
        sync.vs   = int'(vpos) >= video_timing_pkg::VS_START &&
                    int'(vpos) <  video_timing_pkg::VS_START + video_timing_pkg::VS_LEN;
        sync.lhbl = int'(hpos) < video_timing_pkg::H_VIS;
        sync.lvbl = int'(vpos) < video_timing_pkg::V_VIS;
    end

    // Both strobes mark the edge that enters the new position
    assign line_start   = pxl_cen && h_wrap;                                    // Into hpos 0
    assign hblank_start = pxl_cen && int'(hpos) == video_timing_pkg::H_VIS - 1; // Into H_VIS

    a_pos_range: assert property (@(posedge clk) disable iff (!rst_n)
        int'(hpos) < video_timing_pkg::H_TOTAL && int'(vpos) < video_timing_pkg::V_TOTAL);

endmodule

//--- hw/tile_layer.sv
/* 6x4 map of 8x8 tiles, no scroll or flip
   Map writes past byte 23 are dropped; pixel is 0 outside the visible area */
`timescale 1ns/1ps

module tile_layer (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      pxl_cen,
    input  video_gfx_pkg::cpu_bus_t   cpu,
    input  logic                      vram_cs,
    input  video_gfx_pkg::prog_bus_t  prog,
    input  logic                      prog_we,
    input  video_timing_pkg::hpos_t   hpos,
    input  video_timing_pkg::vpos_t   vpos,
    output video_gfx_pkg::pxl_t       pxl
);

    localparam int MAP_W = video_timing_pkg::H_VIS / video_gfx_pkg::TILE_W;
    localparam int MAP_N = MAP_W * (video_timing_pkg::V_VIS / video_gfx_pkg::TILE_W);
    localparam int PAT_N = video_gfx_pkg::PAT_CODES * video_gfx_pkg::TILE_W *
                           video_gfx_pkg::TILE_W / 2;

    logic [7:0] vram    [MAP_N];
    logic [7:0] pat_rom [PAT_N];
    logic [4:0] map_idx;
    logic [7:0] code;
    logic [7:0] pat_byte;
    logic       visible;

    // Map row from vpos[4:3], column from hpos[5:3]
    assign map_idx  = 5'(int'(vpos[4:3]) * MAP_W + int'(hpos[5:3]));
    assign code     = vram[map_idx];
    assign pat_byte = pat_rom[{code[2:0], vpos[2:0], hpos[2:1]}]; // Two pixels per byte
    assign visible  = int'(hpos) < video_timing_pkg::H_VIS &&
                      int'(vpos) < video_timing_pkg::V_VIS;

    always_ff @(posedge clk) begin
        if (cpu.we && vram_cs && int'(cpu.addr[4:0]) < MAP_N) begin
            vram[cpu.addr[4:0]] <= cpu.data;
        end
        if (prog_we) begin
            pat_rom[prog.addr[7:0]] <= prog.data;
        end
    end

    // Low nibble holds the left pixel of each pair
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pxl <= '0;
        end else if (pxl_cen) begin
            if (!visible) begin
                pxl <= '0;
            end else begin
                pxl <= hpos[0] ? pat_byte[7:4] : pat_byte[3:0];
            end
        end
    end

endmodule

//--- hw/obj_line_engine.sv
/* Four 8x8 objects drawn during hblank into a double line buffer for the next line
   Two pixels are drawn per clk, so the scan needs under 32 clk; later entries win */
`timescale 1ns/1ps

module obj_line_engine (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      pxl_cen,
    input  video_gfx_pkg::cpu_bus_t   cpu,
    input  logic                      objram_cs,
    input  video_gfx_pkg::prog_bus_t  prog,
    input  logic                      prog_we,
    input  video_timing_pkg::hpos_t   hpos,
    input  video_timing_pkg::vpos_t   vpos,
    input  logic                      line_start,
    input  logic                      hblank_start,
    output video_gfx_pkg::pxl_t       pxl
);

    localparam int PAT_N = video_gfx_pkg::PAT_CODES * video_gfx_pkg::TILE_W *
                           video_gfx_pkg::TILE_W / 2;

    typedef enum logic [1:0] {IDLE, FETCH, CHECK, DRAW} state_t;

    video_gfx_pkg::obj_entry_u obj_ram [video_gfx_pkg::N_OBJ];
    logic [7:0]                pat_rom [PAT_N];
    logic [3:0]                lbuf    [2][video_timing_pkg::H_VIS];

    state_t                    state;
    video_gfx_pkg::obj_entry_u ent;
    video_timing_pkg::vpos_t   tgt;      // Line being drawn
    logic [1:0]                idx;
    logic [1:0]                pair;     // Pixel pair within the pattern row
    logic [2:0]                row;
    logic                      page;     // Half on display
    logic [8:0]                dy;
    logic [8:0]                col0;
    logic [8:0]                col1;
    logic [7:0]                pat_byte;
    logic                      hit;
    logic                      last;

    // Nine bits so that y near 255 does not wrap onto the top lines
    assign dy       = {3'b0, tgt} - {1'b0, ent.f.y};
    assign hit      = ent.f.attr[7] && dy[8:3] == '0;
    assign last     = int'(idx) == video_gfx_pkg::N_OBJ - 1;
    assign pat_byte = pat_rom[{ent.f.code[2:0], row, pair}];
    assign col0     = {1'b0, ent.f.x} + {6'b0, pair, 1'b0};
    assign col1     = col0 + 9'd1;

    always_ff @(posedge clk) begin
        if (cpu.we && objram_cs) begin
            obj_ram[cpu.addr[3:2]].bytes[cpu.addr[1:0]] <= cpu.data;
        end
        if (prog_we) begin
            pat_rom[prog.addr[7:0]] <= prog.data;
        end
        if (state == FETCH) begin
            ent <= obj_ram[idx];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= IDLE;
            idx   <= '0;
            pair  <= '0;
            row   <= '0;
            tgt   <= '0;
        end else begin
            case (state)
                IDLE: if (hblank_start) begin
                    idx   <= '0;
                    tgt   <= int'(vpos) == video_timing_pkg::V_TOTAL - 1 ? '0 : vpos + 1'b1;
                    state <= FETCH;
                end
                FETCH: state <= CHECK;
                CHECK: begin
                    row  <= dy[2:0];
                    pair <= '0;
                    if (hit) begin
                        state <= DRAW;
                    end else if (last) begin
                        state <= IDLE;
                    end else begin
                        idx   <= idx + 1'b1;
                        state <= FETCH;
                    end
                end
                DRAW: begin
                    pair <= pair + 1'b1;
                    if (pair == 2'd3) begin
                        idx   <= idx + 1'b1;
                        state <= last ? IDLE : FETCH;
                    end
                end
            endcase
        end
    end

    // Display side reads and clears, draw side fills the other half
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            page <= 1'b0;
            pxl  <= '0;
            for (int p = 0; p < 2; p++) begin
                for (int c = 0; c < video_timing_pkg::H_VIS; c++) begin
                    lbuf[p][c] <= '0;
                end
            end
        end else begin
            if (line_start) page <= ~page;
            if (pxl_cen) begin
                if (int'(hpos) < video_timing_pkg::H_VIS) begin
                    pxl              <= lbuf[page][hpos];
                    lbuf[page][hpos] <= '0;
                end else begin
                    pxl <= '0;
                end
            end
            if (state == DRAW) begin
                if (int'(col0) < video_timing_pkg::H_VIS && pat_byte[3:0] != '0) begin
                    lbuf[!page][col0[5:0]] <= pat_byte[3:0];
                end
                if (int'(col1) < video_timing_pkg::H_VIS && pat_byte[7:4] != '0) begin
                    lbuf[!page][col1[5:0]] <= pat_byte[7:4];
                end
            end
        end
    end

    a_no_draw_at_swap: assert property (@(posedge clk) disable iff (!rst_n)
        line_start |-> state != DRAW);
    a_idle_at_line: assert property (@(posedge clk) disable iff (!rst_n)
        hpos == '0 |-> state == IDLE);

endmodule

//--- hw/color_mixer.sv
/* Objects always cover tiles; palette 0-15 for tiles, 16-31 for objects
   sync_in must already carry one pxl_cen of delay to line up with the layers */
`timescale 1ns/1ps

module color_mixer (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          pxl_cen,
    input  video_gfx_pkg::prog_bus_t      prog,
    input  logic                          prog_we,
    input  video_gfx_pkg::pxl_t           obj_pxl,
    input  video_gfx_pkg::pxl_t           tile_pxl,
    input  video_timing_pkg::video_sync_t sync_in,
    output video_timing_pkg::video_sync_t sync_out,
    output video_gfx_pkg::rgb_t           rgb
);

    video_gfx_pkg::rgb_t pal [32];
    logic [4:0]          pal_idx;
    logic                in_vis;

    assign pal_idx = obj_pxl != '0 ? {1'b1, obj_pxl} : {1'b0, tile_pxl};
    assign in_vis  = sync_in.lhbl && sync_in.lvbl;

    // Even byte carries red, odd byte green and blue
    always_ff @(posedge clk) begin
        if (prog_we) begin
            if (prog.addr[0]) begin
                pal[prog.addr[5:1]].green <= prog.data[7:4];
                pal[prog.addr[5:1]].blue  <= prog.data[3:0];
            end else begin
                pal[prog.addr[5:1]].red <= prog.data[3:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sync_out <= '0;
            rgb      <= '0;
        end else if (pxl_cen) begin
            sync_out <= sync_in;
            rgb      <= in_vis ? pal[pal_idx] : '0;   // Black in blank
        end
    end

    a_blank_black: assert property (@(posedge clk) disable iff (!rst_n)
        !(sync_out.lhbl && sync_out.lvbl) |-> rgb == '0);

endmodule

//--- hw/mini_video.sv
/* Tile and sprite video top; rgb and sync_out lag the counters by 2 pxl_cen
   pxl_cen is expected every second clk; CPU writes only, no read back */
`timescale 1ns/1ps

module mini_video (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          pxl_cen,
    input  video_gfx_pkg::cpu_bus_t       cpu,
    input  logic                          vram_cs,
    input  logic                          objram_cs,
    input  video_gfx_pkg::prog_bus_t      prog,
    output video_timing_pkg::video_sync_t sync_out,
    output video_gfx_pkg::rgb_t           rgb
);

    video_timing_pkg::hpos_t       hpos;
    video_timing_pkg::vpos_t       vpos;
    video_timing_pkg::video_sync_t sync_raw;
    video_timing_pkg::video_sync_t sync_dly;   // Matches the layer latency
    video_gfx_pkg::pxl_t           tile_pxl;
    video_gfx_pkg::pxl_t           obj_pxl;
    logic                          line_start;
    logic                          hblank_start;
    logic                          prog_tile_we;
    logic                          prog_obj_we;
    logic                          prog_pal_we;

    assign prog_tile_we = prog.en && prog.addr[9:8] == video_gfx_pkg::PROG_TILE;
    assign prog_obj_we  = prog.en && prog.addr[9:8] == video_gfx_pkg::PROG_OBJ;
    assign prog_pal_we  = prog.en && prog.addr[9:8] == video_gfx_pkg::PROG_PAL;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sync_dly <= '0;
        end else if (pxl_cen) begin
            sync_dly <= sync_raw;
        end
    end

    video_timer u_timer (
        .clk          ( clk          ),
        .rst_n        ( rst_n        ),
        .pxl_cen      ( pxl_cen      ),
        .hpos         ( hpos         ),
        .vpos         ( vpos         ),
        .sync         ( sync_raw     ),
        .line_start   ( line_start   ),
        .hblank_start ( hblank_start )
    );

    tile_layer u_tiles (
        .clk     ( clk          ),
        .rst_n   ( rst_n        ),
        .pxl_cen ( pxl_cen      ),
        .cpu     ( cpu          ),
        .vram_cs ( vram_cs      ),
        .prog    ( prog         ),
        .prog_we ( prog_tile_we ),
        .hpos    ( hpos         ),
        .vpos    ( vpos         ),
        .pxl     ( tile_pxl     )
    );

    obj_line_engine u_obj (
        .clk          ( clk          ),
        .rst_n        ( rst_n        ),
        .pxl_cen      ( pxl_cen      ),
        .cpu          ( cpu          ),
        .objram_cs    ( objram_cs    ),
        .prog         ( prog         ),
        .prog_we      ( prog_obj_we  ),
        .hpos         ( hpos         ),
        .vpos         ( vpos         ),
        .line_start   ( line_start   ),
        .hblank_start ( hblank_start ),
        .pxl          ( obj_pxl      )
    );

    color_mixer u_mix (
        .clk      ( clk         ),
        .rst_n    ( rst_n       ),
        .pxl_cen  ( pxl_cen     ),
        .prog     ( prog        ),
        .prog_we  ( prog_pal_we ),
        .obj_pxl  ( obj_pxl     ),
        .tile_pxl ( tile_pxl    ),
        .sync_in  ( sync_dly    ),
        .sync_out ( sync_out    ),
        .rgb      ( rgb         )
    );

endmodule

//--- testbench/mini_video_tb.sv
/* Random scene with a reference frame model, checked over three frames after loading
   Scene changes are written during vertical blank so that the next frame shows them */
`timescale 1ns/1ps

module mini_video_tb;

    localparam int FRAME_PIX    = video_timing_pkg::H_TOTAL * video_timing_pkg::V_TOTAL;
    localparam int FRAME_CLK    = 2 * FRAME_PIX;                 // pxl_cen every second clk
    localparam int LOAD_CLK     = 5 + 16 + 24 + 256 + 256 + 64 + 8;
    localparam int WATCHDOG_CLK = LOAD_CLK + 8 * FRAME_CLK;     // Alignment waits included
    localparam int MAP_W        = 6;
    localparam int VSYNC_LINE   = 33;                            // Scene writes go here

    logic                          clk;
    logic                          rst_n;
    logic                          pxl_cen;
    video_gfx_pkg::cpu_bus_t       cpu;
    logic                          vram_cs;
    logic                          objram_cs;
    video_gfx_pkg::prog_bus_t      prog;
    video_timing_pkg::video_sync_t sync_out;
    video_gfx_pkg::rgb_t           rgb;

    int                  ncen;        // pxl_cen edges seen by the DUT since reset
    int                  tests;
    int                  checks;
    int                  errors;
    logic [31:0]         rng;
    logic [7:0]          tile_pat  [256];
    logic [7:0]          obj_pat   [256];
    logic [7:0]          tile_code [24];
    logic [7:0]          obj_y     [4];
    logic [7:0]          obj_x     [4];
    logic [7:0]          obj_code  [4];
    logic [7:0]          obj_attr  [4];
    logic                obj_en    [4];
    video_gfx_pkg::rgb_t pal       [32];

    mini_video uut (
        .clk       ( clk       ),
        .rst_n     ( rst_n     ),
        .pxl_cen   ( pxl_cen   ),
        .cpu       ( cpu       ),
        .vram_cs   ( vram_cs   ),
        .objram_cs ( objram_cs ),
        .prog      ( prog      ),
        .sync_out  ( sync_out  ),
        .rgb       ( rgb       )
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        pxl_cen <= ~pxl_cen;
        if (rst_n && pxl_cen) ncen <= ncen + 1;   // Same values the DUT samples
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    function automatic video_timing_pkg::video_sync_t exp_sync(input int h, input int v);
        video_timing_pkg::video_sync_t s;
        s.hs   = h >= 52 && h < 56;
        s.vs   = v >= 35 && v < 37;
        s.lhbl = h < 48;
        s.lvbl = v < 32;
        return s;
    endfunction

    // Objects cover tiles, later entries cover earlier ones, pixel 0 is see-through
    function automatic video_gfx_pkg::rgb_t exp_rgb(input int h, input int v);
        int         code;
        int         i;
        int         dx;
        int         dy;
        logic [7:0] b;
        logic [3:0] tp;
        logic [3:0] op;
        logic [3:0] p;
        if (h >= 48 || v >= 32) return '0;
        code = tile_code[(v / 8) * MAP_W + h / 8] % 8;
        b    = tile_pat[code * 32 + (v % 8) * 4 + (h % 8) / 2];
        tp   = (h % 2 == 1) ? b[7:4] : b[3:0];
        op   = '0;
        for (i = 0; i < 4; i++) begin
            dx = h - int'(obj_x[i]);
            dy = v - int'(obj_y[i]);
            if (obj_en[i] && dx >= 0 && dx < 8 && dy >= 0 && dy < 8) begin
                b = obj_pat[(obj_code[i] % 8) * 32 + dy * 4 + dx / 2];
                p = (dx % 2 == 1) ? b[7:4] : b[3:0];
                if (p != '0) op = p;
            end
        end
        return (op != '0) ? pal[16 + op] : pal[tp];
    endfunction

    task automatic check_rgb(input string name, input int h, input int v,
                             input video_gfx_pkg::rgb_t exp, input video_gfx_pkg::rgb_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("MISMATCH %s rgb at h=%0d v=%0d: expected %h, actual %h",
                     name, h, v, exp, act);
        end
    endtask

    task automatic check_sync(input string name, input int h, input int v,
                              input video_timing_pkg::video_sync_t exp,
                              input video_timing_pkg::video_sync_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("MISMATCH %s sync at h=%0d v=%0d: expected %b, actual %b",
                     name, h, v, exp, act);
        end
    endtask

    task automatic cpu_write(input logic [7:0] addr, input logic [7:0] data, input logic to_obj);
        @(posedge clk);
        cpu       <= '{addr: addr, data: data, we: 1'b1};
        vram_cs   <= !to_obj;
        objram_cs <= to_obj;
        prog.en   <= 1'b0;
    endtask

    task automatic prog_write(input logic [1:0] region, input logic [7:0] offs,
                              input logic [7:0] data);
        @(posedge clk);
        prog      <= '{addr: {region, offs}, data: data, en: 1'b1};
        cpu.we    <= 1'b0;
        vram_cs   <= 1'b0;
        objram_cs <= 1'b0;
    endtask

    task automatic bus_idle();
        @(posedge clk);
        cpu.we    <= 1'b0;
        vram_cs   <= 1'b0;
        objram_cs <= 1'b0;
        prog.en   <= 1'b0;
    endtask

    // Byte 3 is y, then x, code and attr
    task automatic put_obj(input int i);
        cpu_write(8'(i * 4 + 3), obj_y[i], 1'b1);
        cpu_write(8'(i * 4 + 2), obj_x[i], 1'b1);
        cpu_write(8'(i * 4 + 1), obj_code[i], 1'b1);
        cpu_write(8'(i * 4), {obj_en[i], obj_attr[i][6:0]}, 1'b1);
    endtask

    task automatic next_sample();
        int start;
        start = ncen;
        while (ncen == start) @(negedge clk);
    endtask

    task automatic wait_raw_line(input int line);
        do begin
            next_sample();
        end while ((ncen / video_timing_pkg::H_TOTAL) % video_timing_pkg::V_TOTAL != line);
    endtask

    task automatic load_scene();
        int         i;
        logic [7:0] b;
        rng      = xorshift32(rng);
        obj_y[0] = 8'(rng % 24);
        obj_x[0] = 8'((rng >> 8) % 40);
        obj_y[1] = obj_y[0] + 8'd2;       // Overlaps object 0
        obj_x[1] = obj_x[0] + 8'd3;
        obj_y[2] = 8'((rng >> 16) % 28);
        obj_x[2] = 8'd44;                 // Clipped at column 48
        obj_y[3] = 8'd28;                 // Runs into the bottom blank
        obj_x[3] = 8'((rng >> 24) % 40);
        for (i = 0; i < 4; i++) begin
            rng         = xorshift32(rng);
            obj_code[i] = rng[7:0];
            obj_attr[i] = rng[15:8];
            obj_en[i]   = 1'b0;
            put_obj(i);
        end
        for (i = 0; i < 24; i++) begin
            rng          = xorshift32(rng);
            tile_code[i] = rng[7:0];
            cpu_write(8'(i), tile_code[i], 1'b0);
        end
        for (i = 0; i < 256; i++) begin
            rng         = xorshift32(rng);
            tile_pat[i] = rng[7:0];
            prog_write(video_gfx_pkg::PROG_TILE, 8'(i), tile_pat[i]);
            b = rng[23:16];
            if (rng[12]) b[3:0] = '0;     // Plenty of transparent pixels
            if (rng[13]) b[7:4] = '0;
            obj_pat[i] = b;
            prog_write(video_gfx_pkg::PROG_OBJ, 8'(i), b);
        end
        for (i = 0; i < 32; i++) begin
            rng    = xorshift32(rng);
            pal[i] = rng[11:0];
            prog_write(video_gfx_pkg::PROG_PAL, 8'(2 * i), {rng[15:12], pal[i].red});
            prog_write(video_gfx_pkg::PROG_PAL, 8'(2 * i + 1), {pal[i].green, pal[i].blue});
        end
        bus_idle();
    endtask

    // Output lags the counters by two strobes
    task automatic check_frame(input string name);
        int i;
        int n;
        int h;
        int v;
        int chk0;
        int err0;
        chk0 = checks;
        err0 = errors;
        do begin
            next_sample();
        end while ((ncen - 2) % FRAME_PIX != 0);
        for (i = 0; i < FRAME_PIX; i++) begin
            if (i != 0) next_sample();
            n = ncen - 2;
            h = n % video_timing_pkg::H_TOTAL;
            v = (n / video_timing_pkg::H_TOTAL) % video_timing_pkg::V_TOTAL;
            check_sync(name, h, v, exp_sync(h, v), sync_out);
            check_rgb(name, h, v, exp_rgb(h, v), rgb);
        end
        tests++;
        $display("test %s: %0d checks, %0d errors", name, checks - chk0, errors - err0);
    endtask

    initial begin
        #(WATCHDOG_CLK * 20);
        $display("Timeout: the run did not finish within %0d clock cycles", WATCHDOG_CLK);
        $display("Checks failed");
        $finish;
    end

    initial begin
        int i;
        clk       = 1'b0;
        rst_n     = 1'b0;
        pxl_cen   = 1'b0;
        cpu       = '0;
        vram_cs   = 1'b0;
        objram_cs = 1'b0;
        prog      = '0;
        ncen      = 0;
        tests     = 0;
        checks    = 0;
        errors    = 0;
        rng       = 32'hadd381b5;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;

        load_scene();
        wait_raw_line(VSYNC_LINE);
        check_frame("tiles_only");

        wait_raw_line(VSYNC_LINE);
        for (i = 0; i < 4; i++) begin
            obj_en[i] = 1'b1;
            put_obj(i);
        end
        bus_idle();
        check_frame("objects");

        // Only the x byte changes, the rest of entry 0 stays put
        wait_raw_line(VSYNC_LINE);
        rng      = xorshift32(rng);
        obj_x[0] = 8'((int'(obj_x[0]) + 8 + rng % 32) % 48);   // Lands 8 or more columns away
        cpu_write(8'd2, obj_x[0], 1'b1);
        bus_idle();
        check_frame("obj_move");

        $display("summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

//--- mini_video.f
hw/video_timing_pkg.sv
hw/video_gfx_pkg.sv
hw/video_timer.sv
hw/tile_layer.sv
hw/obj_line_engine.sv
hw/color_mixer.sv
hw/mini_video.sv
testbench/mini_video_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f mini_video.f --top-module mini_video_tb \
    -Mdir obj_dir -o mini_video_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/mini_video_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Checks failed" sim.log; then
    echo "Simulation FAILED"
    exit 1
fi
echo "Simulation PASSED"
exit 0
